// ==== hw/l2_pkg.sv ====
package l2_pkg;

    // processor side widths
    typedef logic [29:0] word_addr_t;
    typedef logic [23:0] tag_t;
    typedef logic [3:0] set_idx_t;
    typedef logic [127:0] line_t;

    // memory side block address, tag then set
    typedef logic [27:0] block_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_BACK,
        REFILL
    } miss_state_t;

    // processor request, held as a level while stalled
    typedef struct packed {
        logic       read;
        logic       write;
        word_addr_t addr;
        line_t      wdata;
    } l2_req_t;

    // memory request, held until the mem_ready pulse
    typedef struct packed {
        logic        read;
        logic        write;
        block_addr_t addr;
        line_t       wdata;
    } l2_mem_req_t;

endpackage

// ==== hw/l2_tag_array.sv ====
module l2_tag_array
    import l2_pkg::*;
#(
    parameter bit WRITABLE = 1'b1
) (
    input  logic       clk,
    input  logic       proc_reset,
    input  word_addr_t addr,
    input  logic       lru_touch,
    input  logic       write_hit,
    input  logic       fill,
    output logic       hit,
    output logic       hit_way,
    output logic       victim_way,
    output logic       victim_dirty,
    output tag_t       victim_tag
);

    tag_t             tags [2][16];
    logic [1:0][15:0] valid;
    logic [15:0]      lru;
    logic [1:0]       way_hit;
    set_idx_t         set;
    tag_t             tag;

    assign set = addr[5:2];
    assign tag = addr[29:6];

    assign way_hit[0] = valid[0][set] && (tags[0][set] == tag);
    assign way_hit[1] = valid[1][set] && (tags[1][set] == tag);

    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];
    // lru bit names the way to evict
    assign victim_way = lru[set];
    assign victim_tag = tags[victim_way][set];

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            valid <= '0;
            lru   <= '0;
        end
        else
        begin
            if (fill)
                valid[victim_way][set] <= 1'b1;
            // the other way becomes the victim
            if (lru_touch)
                lru[set] <= ~hit_way;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill)
            tags[victim_way][set] <= tag;
    end

    generate
        if (WRITABLE)
        begin : g_dirty
            logic [1:0][15:0] dirty;

            always_ff @(posedge clk)
            begin
                if (proc_reset)
                    dirty <= '0;
                else if (fill)
                    dirty[victim_way][set] <= 1'b0;
                else if (write_hit)
                    dirty[hit_way][set] <= 1'b1;
            end

            assign victim_dirty = dirty[victim_way][set];
        end
        else
        begin : g_clean
            // read-only cache never holds modified lines
            assign victim_dirty = 1'b0;
        end
    endgenerate

    // a refill must never duplicate a resident tag
    assert property (@(posedge clk) disable iff (proc_reset) !(way_hit[0] && way_hit[1]));

endmodule

// ==== hw/l2_data_array.sv ====
module l2_data_array
    import l2_pkg::*;
#(
    parameter bit WRITABLE = 1'b1
) (
    input  logic     clk,
    input  logic     proc_reset,
    input  set_idx_t set,
    input  logic     hit_way,
    input  logic     victim_way,
    input  logic     write_hit,
    input  logic     fill,
    input  line_t    wdata,
    input  line_t    fill_data,
    output line_t    rdata,
    output line_t    victim_line
);

    line_t lines [2][16];

    assign rdata       = lines[hit_way][set];
    // write-back data for a dirty eviction
    assign victim_line = lines[victim_way][set];

    always_ff @(posedge clk)
    begin
        if (!proc_reset)
        begin
            if (fill)
                lines[victim_way][set] <= fill_data;
            else if (WRITABLE && write_hit)
                lines[hit_way][set] <= wdata;
        end
    end

endmodule

// ==== hw/l2_miss_fsm.sv ====
module l2_miss_fsm
    import l2_pkg::*;
#(
    parameter bit WRITABLE = 1'b1
) (
    input  logic        clk,
    input  logic        proc_reset,
    input  l2_req_t     req,
    input  logic        hit,
    input  logic        victim_dirty,
    input  tag_t        victim_tag,
    input  logic        mem_ready,
    output logic        mem_read,
    output logic        mem_write,
    output block_addr_t mem_addr,
    output logic        stall,
    output logic        fill,
    output logic        write_hit,
    output logic        lru_touch
);

    miss_state_t state;
    logic        req_active;
    block_addr_t wb_addr;
    block_addr_t refill_addr;

    // a read-only cache treats a lone write as no request
    assign req_active = req.read || (WRITABLE && req.write);

    assign stall     = req_active && !hit;
    assign lru_touch = req_active && hit;
    assign write_hit = WRITABLE && req.write && hit;
    assign fill      = (state == REFILL) && mem_ready;

    assign wb_addr     = {victim_tag, req.addr[5:2]};
    assign refill_addr = req.addr[29:2];

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            state     <= IDLE;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (stall)
                    begin
                        if (WRITABLE && victim_dirty)
                        begin
                            mem_write <= 1'b1;
                            state     <= WRITE_BACK;
                        end
                        else
                        begin
                            mem_read <= 1'b1;
                            state    <= REFILL;
                        end
                    end
                end
                WRITE_BACK:
                begin
                    // read rises as write drops, no gap in the level
                    if (mem_ready)
                    begin
                        mem_write <= 1'b0;
                        mem_read  <= 1'b1;
                        state     <= REFILL;
                    end
                end
                REFILL:
                begin
                    if (mem_ready)
                    begin
                        mem_read <= 1'b0;
                        state    <= IDLE;
                    end
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && stall)
            mem_addr <= (WRITABLE && victim_dirty) ? wb_addr : refill_addr;
        else if (state == WRITE_BACK && mem_ready)
            mem_addr <= refill_addr;
    end

    assert property (@(posedge clk) disable iff (proc_reset) !(mem_read && mem_write));

endmodule

// ==== hw/l2_cache.sv ====
module l2_cache
    import l2_pkg::*;
#(
    parameter bit WRITABLE = 1'b1
) (
    input  logic        clk,
    input  logic        proc_reset,
    input  l2_req_t     req,
    input  line_t       mem_rdata,
    input  logic        mem_ready,
    output line_t       rdata,
    output logic        stall,
    output l2_mem_req_t mem_req
);

    logic        hit;
    logic        hit_way;
    logic        victim_way;
    logic        victim_dirty;
    tag_t        victim_tag;
    logic        fill;
    logic        write_hit;
    logic        lru_touch;
    logic        mem_read;
    logic        mem_write;
    block_addr_t mem_addr;
    line_t       victim_line;

    l2_tag_array #(.WRITABLE(WRITABLE)) tags0 (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .addr         (req.addr),
        .lru_touch    (lru_touch),
        .write_hit    (write_hit),
        .fill         (fill),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    l2_data_array #(.WRITABLE(WRITABLE)) data0 (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .set         (req.addr[5:2]),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .write_hit   (write_hit),
        .fill        (fill),
        .wdata       (req.wdata),
        .fill_data   (mem_rdata),
        .rdata       (rdata),
        .victim_line (victim_line)
    );

    l2_miss_fsm #(.WRITABLE(WRITABLE)) fsm0 (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .req          (req),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .mem_ready    (mem_ready),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .stall        (stall),
        .fill         (fill),
        .write_hit    (write_hit),
        .lru_touch    (lru_touch)
    );

    // victim line is only sampled by memory during a write-back
    assign mem_req = '{read: mem_read, write: mem_write, addr: mem_addr, wdata: victim_line};

endmodule

// ==== hw/l2_mem_arbiter.sv ====
module l2_mem_arbiter
    import l2_pkg::*;
(
    input  logic        clk,
    input  logic        proc_reset,
    input  l2_mem_req_t d_mem_req,
    input  l2_mem_req_t i_mem_req,
    input  line_t       mem_rdata,
    input  logic        mem_ready,
    output l2_mem_req_t mem_req,
    output line_t       d_mem_rdata,
    output line_t       i_mem_rdata,
    output logic        d_mem_ready,
    output logic        i_mem_ready
);

    logic d_act;
    logic i_act;
    logic busy;
    logic owner_i;
    logic locked;
    logic sel_i;

    assign d_act = d_mem_req.read || d_mem_req.write;
    assign i_act = i_mem_req.read || i_mem_req.write;

    // owner keeps the port while its level stays up
    assign locked = busy && (owner_i ? i_act : d_act);
    // free port goes to the data cache first
    assign sel_i  = locked ? owner_i : (i_act && !d_act);

    assign mem_req = sel_i ? i_mem_req : d_mem_req;

    assign d_mem_ready = mem_ready && !sel_i;
    assign i_mem_ready = mem_ready && sel_i;
    assign d_mem_rdata = sel_i ? '0 : mem_rdata;
    assign i_mem_rdata = sel_i ? mem_rdata : '0;

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            busy    <= 1'b0;
            owner_i <= 1'b0;
        end
        else
        begin
            busy    <= d_act || i_act;
            owner_i <= sel_i;
        end
    end

    // a granted request holds at the port until its ready pulse
    assert property (@(posedge clk) disable iff (proc_reset)
        (mem_req.read || mem_req.write) && !mem_ready |=> $stable(mem_req));

endmodule

// ==== hw/l2_cache_sys.sv ====
module l2_cache_sys
    import l2_pkg::*;
(
    input  logic        clk,
    input  logic        proc_reset,
    input  l2_req_t     d_req,
    input  l2_req_t     i_req,
    input  line_t       mem_rdata,
    input  logic        mem_ready,
    output line_t       d_rdata,
    output line_t       i_rdata,
    output logic        d_stall,
    output logic        i_stall,
    output l2_mem_req_t mem_req
);

    l2_mem_req_t d_mem_req;
    l2_mem_req_t i_mem_req;
    line_t       d_mem_rdata;
    line_t       i_mem_rdata;
    logic        d_mem_ready;
    logic        i_mem_ready;

    l2_cache #(.WRITABLE(1'b1)) d_cache (
        .clk        (clk),
        .proc_reset (proc_reset),
        .req        (d_req),
        .mem_rdata  (d_mem_rdata),
        .mem_ready  (d_mem_ready),
        .rdata      (d_rdata),
        .stall      (d_stall),
        .mem_req    (d_mem_req)
    );

    // instruction side, no write path
    l2_cache #(.WRITABLE(1'b0)) i_cache (
        .clk        (clk),
        .proc_reset (proc_reset),
        .req        (i_req),
        .mem_rdata  (i_mem_rdata),
        .mem_ready  (i_mem_ready),
        .rdata      (i_rdata),
        .stall      (i_stall),
        .mem_req    (i_mem_req)
    );

    l2_mem_arbiter arb0 (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .d_mem_req   (d_mem_req),
        .i_mem_req   (i_mem_req),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .mem_req     (mem_req),
        .d_mem_rdata (d_mem_rdata),
        .i_mem_rdata (i_mem_rdata),
        .d_mem_ready (d_mem_ready),
        .i_mem_ready (i_mem_ready)
    );

endmodule

// ==== test/l2_mem_model.sv ====
module l2_mem_model
    import l2_pkg::*;
#(
    parameter logic [31:0] SEED     = 32'hb362,
    parameter int          LAT_BITS = 3
) (
    input  logic        clk,
    input  logic        proc_reset,
    input  l2_mem_req_t mem_req,
    output line_t       mem_rdata,
    output logic        mem_ready,
    output int          wr_count
);

    line_t       store [block_addr_t];
    logic [31:0] lfsr;
    int          latency;

    // galois form, shifts right
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    // contents of a block that memory never got written
    function automatic line_t fill_pattern(input block_addr_t ba);
        return {4'ha, ba, 4'h5, ~ba, 4'hc, {ba[13:0], ba[27:14]}, 4'h3, ba ^ 28'h5a5a5a5};
    endfunction

    task automatic draw_latency(output int lat);
        lat = 0;
        for (int i = 0; i < LAT_BITS; i++)
        begin
            lat  = (lat << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    initial
    begin
        lfsr      = SEED;
        mem_ready = 1'b0;
        mem_rdata = '0;
        wr_count  = 0;
        forever
        begin
            @(negedge clk);
            if (!proc_reset && (mem_req.read || mem_req.write))
            begin
                draw_latency(latency);
                repeat (latency) @(negedge clk);
                @(posedge clk);
                #1;
                mem_ready = 1'b1;
                if (mem_req.write)
                begin
                    store[mem_req.addr] = mem_req.wdata;
                    wr_count++;
                end
                else if (store.exists(mem_req.addr))
                    mem_rdata = store[mem_req.addr];
                else
                    mem_rdata = fill_pattern(mem_req.addr);
                // one-cycle ready pulse
                @(posedge clk);
                #1;
                mem_ready = 1'b0;
                mem_rdata = '0;
            end
        end
    end

endmodule

// ==== test/l2_cache_sys_tb.sv ====
module l2_cache_sys_tb
    import l2_pkg::*;
();

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_REQS     = 17;
    // write-back and refill, possibly queued behind the other cache
    localparam int MISS_CYCLES  = 40;
    localparam int TIMEOUT      = (NUM_REQS * MISS_CYCLES + RESET_CYCLES + 4) * PERIOD;

    logic        clk;
    logic        proc_reset;
    l2_req_t     d_req;
    l2_req_t     i_req;
    line_t       mem_rdata;
    logic        mem_ready;
    line_t       d_rdata;
    line_t       i_rdata;
    logic        d_stall;
    logic        i_stall;
    l2_mem_req_t mem_req;
    int          mem_wr_count;
    string       test_name;
    int          mark;

    // last processor write per block, and memory contents after write-backs
    line_t       written [block_addr_t];
    line_t       mem_shadow [block_addr_t];
    block_addr_t wb_log [$];
    block_addr_t refill_log [$];

    l2_cache_sys dut0 (
        .clk        (clk),
        .proc_reset (proc_reset),
        .d_req      (d_req),
        .i_req      (i_req),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .d_rdata    (d_rdata),
        .i_rdata    (i_rdata),
        .d_stall    (d_stall),
        .i_stall    (i_stall),
        .mem_req    (mem_req)
    );

    l2_mem_model #(.SEED(32'hb362)) mem0 (
        .clk        (clk),
        .proc_reset (proc_reset),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .wr_count   (mem_wr_count)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string what, input logic [127:0] exp,
                               input logic [127:0] act);
        assert (act == exp)
        else
            abort_run($sformatf("[ERROR] %s %s: expected %h actual %h",
                                test_name, what, exp, act));
    endtask

    function automatic line_t fill_pattern(input block_addr_t ba);
        return {4'ha, ba, 4'h5, ~ba, 4'hc, {ba[13:0], ba[27:14]}, 4'h3, ba ^ 28'h5a5a5a5};
    endfunction

    // instruction side sees memory only, no coherence with data writes
    function automatic line_t expected_line(input bit icache, input block_addr_t ba);
        if (!icache && written.exists(ba))
            return written[ba];
        if (mem_shadow.exists(ba))
            return mem_shadow[ba];
        return fill_pattern(ba);
    endfunction

    function automatic word_addr_t addr_of(input tag_t tag, input set_idx_t set);
        return {tag, set, 2'b00};
    endfunction

    task automatic read_side(input bit icache, input word_addr_t addr, input bit expect_miss);
        l2_req_t req;
        req = '{read: 1'b1, write: 1'b0, addr: addr, wdata: '0};
        if (icache)
            i_req = req;
        else
            d_req = req;
        @(negedge clk);
        check_value(icache ? "i_stall" : "d_stall", 128'(expect_miss),
                    128'(icache ? i_stall : d_stall));
        while (icache ? i_stall : d_stall)
            @(negedge clk);
        @(posedge clk);
        #1;
        if (icache)
            i_req = '0;
        else
            d_req = '0;
    endtask

    task automatic write_data(input word_addr_t addr, input line_t wdata, input bit expect_miss);
        d_req = '{read: 1'b0, write: 1'b1, addr: addr, wdata: wdata};
        @(negedge clk);
        check_value("d_stall", 128'(expect_miss), 128'(d_stall));
        while (d_stall)
            @(negedge clk);
        @(posedge clk);
        #1;
        written[addr[29:2]] = wdata;
        d_req = '0;
    endtask

    always @(negedge clk)
    begin
        if (proc_reset)
            check_value("mem request in reset", 128'(0), 128'(mem_req.read || mem_req.write));
        else
        begin
            if (d_req.read && !d_stall)
                check_value("d_rdata", expected_line(1'b0, d_req.addr[29:2]), d_rdata);
            if (i_req.read && !i_stall)
                check_value("i_rdata", expected_line(1'b1, i_req.addr[29:2]), i_rdata);
            if (mem_ready && mem_req.write)
            begin
                assert (written.exists(mem_req.addr))
                else
                    abort_run($sformatf("memory write to block %h, which was never written",
                                        mem_req.addr));
                check_value("write-back data", written[mem_req.addr], mem_req.wdata);
                mem_shadow[mem_req.addr] = mem_req.wdata;
                wb_log.push_back(mem_req.addr);
            end
            if (mem_ready && mem_req.read)
                refill_log.push_back(mem_req.addr);
        end
    end

    initial
    begin
        #(TIMEOUT);
        abort_run($sformatf("watchdog expired after %0d time units", TIMEOUT));
    end

    initial
    begin
        clk        = 1'b0;
        proc_reset = 1'b1;
        d_req      = '0;
        i_req      = '0;
        test_name  = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        proc_reset = 1'b0;
        @(negedge clk);
        check_value("mem request after reset", 128'(0), 128'(mem_req.read || mem_req.write));
        @(posedge clk);
        #1;
        read_side(1'b0, addr_of(24'h1, 4'd3), 1'b1);

        test_name = "read_hit";
        mark = refill_log.size();
        read_side(1'b0, addr_of(24'h1, 4'd3), 1'b0);
        check_value("refill count", 128'(mark), 128'(refill_log.size()));

        test_name = "write_hit";
        write_data(addr_of(24'h1, 4'd3), {4{32'hc0de_0001}}, 1'b0);
        read_side(1'b0, addr_of(24'h1, 4'd3), 1'b0);
        // write miss allocates, then lands as a hit
        write_data(addr_of(24'h7, 4'd12), {4{32'hbeef_0002}}, 1'b1);
        read_side(1'b0, addr_of(24'h7, 4'd12), 1'b0);

        test_name = "dirty_evict";
        mark = wb_log.size();
        read_side(1'b0, addr_of(24'h2, 4'd3), 1'b1);
        read_side(1'b0, addr_of(24'h3, 4'd3), 1'b1);
        check_value("write-back count", 128'(mark + 1), 128'(wb_log.size()));
        check_value("write-back block", 128'({24'h1, 4'd3}), 128'(wb_log[$]));
        read_side(1'b0, addr_of(24'h1, 4'd3), 1'b1);

        test_name = "arbitration";
        mark = refill_log.size();
        fork
            read_side(1'b0, addr_of(24'h5, 4'd7), 1'b1);
            read_side(1'b1, addr_of(24'h9, 4'd7), 1'b1);
        join
        check_value("refill count", 128'(mark + 2), 128'(refill_log.size()));
        check_value("first refill", 128'({24'h5, 4'd7}), 128'(refill_log[mark]));
        check_value("second refill", 128'({24'h9, 4'd7}), 128'(refill_log[mark + 1]));

        // touched way survives, the other one goes
        test_name = "lru";
        read_side(1'b0, addr_of(24'h4, 4'd11), 1'b1);
        read_side(1'b0, addr_of(24'h6, 4'd11), 1'b1);
        read_side(1'b0, addr_of(24'h4, 4'd11), 1'b0);
        read_side(1'b0, addr_of(24'h8, 4'd11), 1'b1);
        read_side(1'b0, addr_of(24'h4, 4'd11), 1'b0);
        read_side(1'b0, addr_of(24'h6, 4'd11), 1'b1);

        test_name = "write_log";
        // only the dirty eviction ever writes memory
        check_value("memory write count", 128'(1), 128'(mem_wr_count));
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== l2_cache_sys.f ====
hw/l2_pkg.sv
hw/l2_tag_array.sv
hw/l2_data_array.sv
hw/l2_miss_fsm.sv
hw/l2_cache.sv
hw/l2_mem_arbiter.sv
hw/l2_cache_sys.sv
test/l2_mem_model.sv
test/l2_cache_sys_tb.sv

// ==== Makefile ====
TOP := l2_cache_sys_tb

.PHONY: all run lint clean

all: run

run: obj_dir/$(TOP)
	./obj_dir/$(TOP)

obj_dir/$(TOP): l2_cache_sys.f hw/*.sv test/*.sv
	verilator --binary --timing --assert -j 0 -f l2_cache_sys.f \
		--top-module $(TOP) -o $(TOP)

lint:
	verilator --lint-only -Wall --timing -f l2_cache_sys.f --top-module l2_cache_sys

clean:
	rm -rf obj_dir
